// ==== sources.f ====
+incdir+hdl
hdl/ooo_pkg.sv
hdl/ooo_if.sv
hdl/rename_unit.sv
hdl/add_sub_rs.sv
hdl/cdb_stage.sv
hdl/ooo_add_core.sv
sim/ooo_add_core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the ooo_add_core testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module ooo_add_core_tb \
	-f sources.f -Mdir obj_dir > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "Verilator build failed, see build.log"
	exit 1
fi
./obj_dir/Vooo_add_core_tb > sim.log 2>&1
if [ $? -ne 0 ]; then
	echo "Simulation exited with an error, see sim.log"
	exit 1
fi
cat sim.log
if grep -q "TESTBENCH FAILED" sim.log; then
	exit 1
fi
exit 0

// ==== sim/ooo_add_core_tb.sv ====
`timescale 1ns/10ps
`include "ooo_defines.svh"

module ooo_add_core_tb;
	localparam int RW = $clog2(`OOO_N_GPR);
	localparam int DW = `OOO_DATA_WIDTH;
	localparam int IW = `OOO_IMM_WIDTH;
	localparam int TW = `OOO_TAG_WIDTH;
	localparam int N_TAG = 1 << TW;
	localparam int N_PROG = 16;
	localparam int TIMEOUT = 200;
	localparam int HOLD_START = 6; // Grant forced low in this cycle window
	localparam int HOLD_END = 36;

	typedef struct packed {
		logic [2:0] op; // [0] imm, [1] sub, [2] sl2
		logic [RW-1:0] rd;
		logic [RW-1:0] rs1;
		logic [RW-1:0] rs2;
		logic [IW-1:0] imm;
		logic [DW-1:0] expected;
	} instr_t;

	logic clk;
	logic reset;
	logic in_valid;
	logic in_ready;
	logic [2:0] in_op;
	logic [RW-1:0] in_rd;
	logic [RW-1:0] in_rs1;
	logic [RW-1:0] in_rs2;
	logic [IW-1:0] in_imm;
	logic cdb_grant;
	logic cdb_valid;
	logic [`OOO_TAG_WIDTH-1:0] cdb_tag;
	logic [DW-1:0] cdb_data;
	logic [RW-1:0] read_addr;
	logic [DW-1:0] read_data;
	logic read_busy;

	instr_t prog [N_PROG];
	logic [DW-1:0] model_regs [`OOO_N_GPR];
	logic [DW-1:0] in_expected; // Model result of the instruction on the inputs
	logic [N_TAG-1:0] tag_free;
	logic [DW-1:0] tag_result [N_TAG];
	logic [TW-1:0] new_tag;
	integer seed;
	int errors;
	int issued;
	int seen;
	int cycle;
	logic grant_hold;
	logic ready_low_seen;
	logic timed_out;

	ooo_add_core dut_i (
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.in_op(in_op),
		.in_rd(in_rd),
		.in_rs1(in_rs1),
		.in_rs2(in_rs2),
		.in_imm(in_imm),
		.cdb_grant(cdb_grant),
		.cdb_valid(cdb_valid),
		.cdb_tag(cdb_tag),
		.cdb_data(cdb_data),
		.read_addr(read_addr),
		.read_data(read_data),
		.read_busy(read_busy)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Program order result from the current model registers
	function automatic logic [DW-1:0] model_result(input instr_t ins);
		logic [DW-1:0] a;
		logic [DW-1:0] b;
		a = ins.op[0] ? {{(DW-IW){ins.imm[IW-1]}}, ins.imm} : model_regs[ins.rs2];
		b = ins.op[2] ? model_regs[ins.rs1] << 2 : model_regs[ins.rs1];
		return ins.op[1] ? a - b : a + b;
	endfunction

	function automatic logic [TW-1:0] lowest_free_tag(input logic [N_TAG-1:0] free);
		for (int t = 0; t < N_TAG; t++) begin
			if (free[t]) begin
				return TW'(t);
			end
		end
		return '0;
	endfunction

	task automatic load_program();
		prog[0] = '{3'b001, 3'd1, 3'd0, 3'd0, 16'h0005, 32'h0};
		prog[1] = '{3'b001, 3'd2, 3'd0, 3'd0, 16'hfffd, 32'h0}; // Negative immediate
		prog[2] = '{3'b000, 3'd3, 3'd1, 3'd2, 16'h0000, 32'h0};
		prog[3] = '{3'b111, 3'd4, 3'd1, 3'd0, 16'h0064, 32'h0}; // imm - (r1 << 2)
		prog[4] = '{3'b110, 3'd5, 3'd3, 3'd4, 16'h0000, 32'h0};
		prog[5] = '{3'b001, 3'd6, 3'd5, 3'd0, 16'h0001, 32'h0}; // Dependent chain
		prog[6] = '{3'b001, 3'd6, 3'd6, 3'd0, 16'h0002, 32'h0};
		prog[7] = '{3'b000, 3'd6, 3'd6, 3'd6, 16'h0000, 32'h0};
		prog[8] = '{3'b001, 3'd7, 3'd6, 3'd0, 16'hffff, 32'h0}; // Older write to r7
		prog[9] = '{3'b001, 3'd7, 3'd0, 3'd0, 16'h7fff, 32'h0}; // Younger, ready first
		prog[10] = '{3'b001, 3'd0, 3'd1, 3'd0, 16'h0009, 32'h0};
		prog[11] = '{3'b010, 3'd1, 3'd2, 3'd3, 16'h0000, 32'h0};
		prog[12] = '{3'b000, 3'd2, 3'd0, 3'd1, 16'h0000, 32'h0};
		prog[13] = '{3'b011, 3'd3, 3'd7, 3'd0, 16'h8000, 32'h0};
		prog[14] = '{3'b001, 3'd5, 3'd5, 3'd0, 16'h1234, 32'h0};
		prog[15] = '{3'b000, 3'd4, 3'd4, 3'd3, 16'h0000, 32'h0};
		for (int r = 0; r < `OOO_N_GPR; r++) begin
			model_regs[r] = '0;
		end
		for (int i = 0; i < N_PROG; i++) begin
			prog[i].expected = model_result(prog[i]);
			if (prog[i].rd != '0) begin
				model_regs[prog[i].rd] = prog[i].expected;
			end
		end
	endtask

	task automatic issue_instr(input instr_t ins, input int idx);
		int wait_cycles;
		in_valid <= 1'b1;
		in_op <= ins.op;
		in_rd <= ins.rd;
		in_rs1 <= ins.rs1;
		in_rs2 <= ins.rs2;
		in_imm <= ins.imm;
		in_expected <= ins.expected;
		wait_cycles = 0;
		do begin
			@(posedge clk);
			wait_cycles++;
		end while (!in_ready && wait_cycles < TIMEOUT);
		if (in_ready) begin
			issued++;
		end else begin
			timed_out = 1'b1;
			errors++;
			$display("Timeout: instruction %0d was never accepted", idx);
		end
	endtask

	assign grant_hold = cycle >= HOLD_START && cycle < HOLD_END;

	// Grant driver and CDB monitor
	always @(posedge clk) begin
		cycle <= reset ? 0 : cycle + 1;
		cdb_grant <= !grant_hold && ($random(seed) & 32'd1) != 0;
		if (!reset && grant_hold && !in_ready) begin
			ready_low_seen <= 1'b1;
		end
		if (reset) begin
			tag_free = '1;
		end else begin
			if (in_valid && in_ready) begin // Lowest free tag goes to each accepted issue
				new_tag = lowest_free_tag(tag_free);
				tag_free[new_tag] = 1'b0;
				tag_result[new_tag] = in_expected;
			end
			if (cdb_valid) begin
				seen <= seen + 1;
				assert (!tag_free[cdb_tag]) else begin
					errors++;
					$display("Error: cdb_tag = %h is not in flight", cdb_tag);
				end
				assert (cdb_data === tag_result[cdb_tag]) else begin
					errors++;
					$display("Error: cdb_data = %h (tag %h), expected %h", cdb_data, cdb_tag,
						tag_result[cdb_tag]);
				end
				tag_free[cdb_tag] = 1'b1;
			end
		end
	end

	initial begin
		int wait_cycles;
		seed = 21638;
		reset = 1'b1;
		in_valid = 1'b0;
		in_op = '0;
		in_rd = '0;
		in_rs1 = '0;
		in_rs2 = '0;
		in_imm = '0;
		in_expected = '0;
		cdb_grant = 1'b0;
		read_addr = '0;
		errors = 0;
		issued = 0;
		seen = 0;
		cycle = 0;
		ready_low_seen = 1'b0;
		timed_out = 1'b0;
		load_program();
		repeat (8) @(posedge clk);
		assert (!in_ready) else begin
			errors++;
			$display("Error: in_ready = %h during reset, expected 0", in_ready);
		end
		reset <= 1'b0;
		for (int i = 0; i < N_PROG && !timed_out; i++) begin
			issue_instr(prog[i], i);
		end
		in_valid <= 1'b0;
		wait_cycles = 0;
		while (!timed_out && seen < issued && wait_cycles < TIMEOUT) begin
			@(posedge clk);
			wait_cycles++;
		end
		if (!timed_out && seen < issued) begin
			timed_out = 1'b1;
			errors++;
			$display("Timeout: only %0d of %0d results were broadcast", seen, issued);
		end
		if (!timed_out) begin
			repeat (10) @(posedge clk); // Catch extra broadcasts
			assert (seen == issued) else begin
				errors++;
				$display("Error: broadcast count = %h, expected %h", seen, issued);
			end
			assert (ready_low_seen) else begin
				errors++;
				$display("in_ready never fell while the grant was held low");
			end
			for (int r = 0; r < `OOO_N_GPR; r++) begin
				read_addr <= RW'(r);
				@(posedge clk);
				assert (!read_busy) else begin
					errors++;
					$display("Error: read_busy r%0d = %h, expected 0", r, read_busy);
				end
				assert (read_data === model_regs[r]) else begin
					errors++;
					$display("Error: read_data r%0d = %h, expected %h", r, read_data,
						model_regs[r]);
				end
			end
		end
		$display("Issued %0d, broadcast %0d, errors %0d", issued, seen, errors);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end
endmodule

// ==== hdl/ooo_add_core.sv ====
`timescale 1ns/10ps
`include "ooo_defines.svh"

module ooo_add_core (
	input logic clk,
	input logic reset,
	input logic in_valid,
	output logic in_ready,
	input logic [2:0] in_op,
	input logic [$clog2(`OOO_N_GPR)-1:0] in_rd,
	input logic [$clog2(`OOO_N_GPR)-1:0] in_rs1,
	input logic [$clog2(`OOO_N_GPR)-1:0] in_rs2,
	input logic [`OOO_IMM_WIDTH-1:0] in_imm,
	input logic cdb_grant,
	output logic cdb_valid,
	output logic [`OOO_TAG_WIDTH-1:0] cdb_tag,
	output logic [`OOO_DATA_WIDTH-1:0] cdb_data,
	input logic [$clog2(`OOO_N_GPR)-1:0] read_addr,
	output logic [`OOO_DATA_WIDTH-1:0] read_data,
	output logic read_busy
);
	logic req_valid;
	logic req_ready;
	logic [`OOO_TAG_WIDTH-1:0] rs_tag;
	logic [`OOO_DATA_WIDTH-1:0] rs_result;

	issue_if issue_bus ();
	cdb_if cdb_bus ();

	rename_unit rename_i (
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.in_op(in_op),
		.in_rd(in_rd),
		.in_rs1(in_rs1),
		.in_rs2(in_rs2),
		.in_imm(in_imm),
		.issue(issue_bus.source),
		.cdb(cdb_bus.sink),
		.read_addr(read_addr),
		.read_data(read_data),
		.read_busy(read_busy)
	);

	add_sub_rs rs_i (
		.clk(clk),
		.reset(reset),
		.issue(issue_bus.sink),
		.cdb(cdb_bus.sink),
		.req_valid(req_valid),
		.req_ready(req_ready),
		.tag(rs_tag),
		.result(rs_result)
	);

	cdb_stage cdb_i (
		.clk(clk),
		.reset(reset),
		.req_valid(req_valid),
		.req_ready(req_ready),
		.tag(rs_tag),
		.result(rs_result),
		.cdb_grant(cdb_grant),
		.cdb(cdb_bus.source)
	);

	assign cdb_valid = cdb_bus.bus.valid;
	assign cdb_tag = cdb_bus.bus.tag;
	assign cdb_data = cdb_bus.bus.data;
endmodule

// ==== hdl/cdb_stage.sv ====
`timescale 1ns/10ps
`include "ooo_defines.svh"

module cdb_stage (
	input logic clk,
	input logic reset,
	input logic req_valid,
	output logic req_ready,
	input logic [`OOO_TAG_WIDTH-1:0] tag,
	input logic [`OOO_DATA_WIDTH-1:0] result,
	input logic cdb_grant,
	cdb_if.source cdb
);
	logic full;
	logic [`OOO_TAG_WIDTH-1:0] tag_q;
	logic load;

	assign req_ready = !full || cdb_grant; // Empty, or draining this cycle
	assign load = req_valid && req_ready;

	always_ff @(posedge clk) begin
		if (reset) begin
			full <= 1'b0;
		end else if (load) begin
			full <= 1'b1;
		end else if (cdb_grant) begin
			full <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			tag_q <= tag;
		end
	end

	// Result register in the station lines up with tag_q
	assign cdb.bus.valid = full && cdb_grant;
	assign cdb.bus.tag = tag_q;
	assign cdb.bus.data = result;
endmodule

// ==== hdl/add_sub_rs.sv ====
`timescale 1ns/10ps
`include "ooo_defines.svh"

module add_sub_rs (
	input logic clk,
	input logic reset,
	issue_if.sink issue,
	cdb_if.sink cdb,
	output logic req_valid,
	input logic req_ready,
	output logic [`OOO_TAG_WIDTH-1:0] tag,
	output logic [`OOO_DATA_WIDTH-1:0] result
);
	import ooo_pkg::*;

	localparam int N_ENTRY = 2;
	localparam int DW = `OOO_DATA_WIDTH;

	rs_entry_t e [N_ENTRY]; // Filled from index 0, oldest first
	rs_entry_t e_upd [N_ENTRY];
	rs_entry_t e_new;
	cdb_t opd_a;
	cdb_t opd_b;
	logic [N_ENTRY-1:0] entry_ready;
	logic disp_idx;
	logic dispatch;

	// Wake up a waiting operand from the broadcast
	function automatic cdb_t fill_opd(input cdb_t src, input cdb_t bus, input logic shift);
		cdb_t o;
		o = src;
		if (!src.valid && bus.valid && bus.tag == src.tag) begin
			o.valid = 1'b1;
			o.data = shift ? bus.data << 2 : bus.data;
		end
		return o;
	endfunction

	always_comb begin
		opd_a = issue.rs2;
		if (issue.op[0]) begin // Immediate form
			opd_a.valid = 1'b1;
			opd_a.tag = '0;
			opd_a.data = DW'($signed(issue.imm));
		end
		opd_b = issue.rs1;
		if (issue.op[2] && opd_b.valid) begin
			opd_b.data = opd_b.data << 2;
		end

		e_new.valid = issue.valid && issue.ready;
		e_new.tag = issue.tag;
		e_new.add_or_sub = issue.op[1] ? SUB : ADD;
		e_new.sl2 = issue.op[2];
		e_new.opd[0] = fill_opd(opd_a, cdb.bus, 1'b0);
		e_new.opd[1] = fill_opd(opd_b, cdb.bus, issue.op[2]);
	end

	always_comb begin
		for (int i = 0; i < N_ENTRY; i++) begin
			e_upd[i] = e[i];
			e_upd[i].opd[0] = fill_opd(e[i].opd[0], cdb.bus, 1'b0);
			e_upd[i].opd[1] = fill_opd(e[i].opd[1], cdb.bus, e[i].sl2);
			entry_ready[i] = e[i].valid && e[i].opd[0].valid && e[i].opd[1].valid;
		end
	end

	assign disp_idx = !entry_ready[0]; // Older entry first
	assign req_valid = |entry_ready;
	assign tag = e[disp_idx].tag;
	assign dispatch = req_valid && req_ready;
	assign issue.ready = dispatch || !e[N_ENTRY-1].valid;

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < N_ENTRY; i++) begin
				e[i] <= '0;
			end
		end else if (dispatch) begin
			if (!disp_idx) begin // Shift entry 1 down
				e[0] <= e[1].valid ? e_upd[1] : e_new;
			end else begin
				e[0] <= e_upd[0];
			end
			e[1] <= e[1].valid ? e_new : '0;
		end else begin
			e[0] <= e[0].valid ? e_upd[0] : e_new;
			e[1] <= e[1].valid ? e_upd[1] : (e[0].valid ? e_new : '0);
		end
	end

	// ALU, result follows dispatch by one cycle
	always_ff @(posedge clk) begin
		if (dispatch) begin
			if (e[disp_idx].add_or_sub == SUB) begin
				result <= e[disp_idx].opd[0].data - e[disp_idx].opd[1].data;
			end else begin
				result <= e[disp_idx].opd[0].data + e[disp_idx].opd[1].data;
			end
		end
	end
endmodule

// ==== hdl/rename_unit.sv ====
`timescale 1ns/10ps
`include "ooo_defines.svh"

module rename_unit (
	input logic clk,
	input logic reset,
	input logic in_valid,
	output logic in_ready,
	input logic [2:0] in_op,
	input logic [$clog2(`OOO_N_GPR)-1:0] in_rd,
	input logic [$clog2(`OOO_N_GPR)-1:0] in_rs1,
	input logic [$clog2(`OOO_N_GPR)-1:0] in_rs2,
	input logic [`OOO_IMM_WIDTH-1:0] in_imm,
	issue_if.source issue,
	cdb_if.sink cdb,
	input logic [$clog2(`OOO_N_GPR)-1:0] read_addr,
	output logic [`OOO_DATA_WIDTH-1:0] read_data,
	output logic read_busy
);
	localparam int TW = `OOO_TAG_WIDTH;
	localparam int N_TAG = 1 << TW;
	localparam int N_GPR = `OOO_N_GPR;

	logic [N_TAG-1:0] free;
	logic [TW-1:0] alloc_tag;
	logic tag_avail;
	logic issue_fire;

	logic [N_GPR-1:0] reg_present;
	logic [TW-1:0] reg_tag [N_GPR];
	logic [`OOO_DATA_WIDTH-1:0] reg_data [N_GPR];

	// Lowest free tag wins
	always_comb begin
		alloc_tag = '0;
		for (int i = N_TAG - 1; i >= 0; i--) begin
			if (free[i]) begin
				alloc_tag = TW'(i);
			end
		end
	end

	assign tag_avail = |free;
	assign in_ready = issue.ready && tag_avail && !reset;
	assign issue_fire = in_valid && in_ready;

	assign issue.valid = issue_fire;
	assign issue.op = in_op;
	assign issue.imm = in_imm;
	assign issue.tag = alloc_tag;

	// Register read, value or pending producer tag
	always_comb begin
		issue.rs1.valid = reg_present[in_rs1];
		issue.rs1.tag = reg_tag[in_rs1];
		issue.rs1.data = reg_data[in_rs1];
		issue.rs2.valid = reg_present[in_rs2];
		issue.rs2.tag = reg_tag[in_rs2];
		issue.rs2.data = reg_data[in_rs2];
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			free <= '1;
		end else begin
			if (cdb.bus.valid) begin
				free[cdb.bus.tag] <= 1'b1;
			end
			if (issue_fire) begin
				free[alloc_tag] <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			reg_present <= '1;
			for (int i = 0; i < N_GPR; i++) begin
				reg_data[i] <= '0;
			end
		end else begin
			if (cdb.bus.valid) begin
				for (int i = 1; i < N_GPR; i++) begin
					if (!reg_present[i] && reg_tag[i] == cdb.bus.tag) begin // Stale tags ignored
						reg_present[i] <= 1'b1;
						reg_data[i] <= cdb.bus.data;
					end
				end
			end
			if (issue_fire && in_rd != '0) begin // Younger rename wins over write-back
				reg_present[in_rd] <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (issue_fire && in_rd != '0) begin
			reg_tag[in_rd] <= alloc_tag;
		end
	end

	assign read_data = reg_data[read_addr];
	assign read_busy = !reg_present[read_addr];
endmodule

// ==== hdl/ooo_if.sv ====
`timescale 1ns/10ps
`include "ooo_defines.svh"

interface issue_if;
	import ooo_pkg::*;

	logic valid;
	logic ready;
	logic [2:0] op;
	logic [`OOO_IMM_WIDTH-1:0] imm;
	logic [`OOO_TAG_WIDTH-1:0] tag; // Destination tag
	cdb_t rs1;
	cdb_t rs2;

	modport source (
		output valid, op, imm, tag, rs1, rs2,
		input ready
	);

	modport sink (
		input valid, op, imm, tag, rs1, rs2,
		output ready
	);
endinterface

interface cdb_if;
	import ooo_pkg::*;

	cdb_t bus;

	modport source (
		output bus
	);

	modport sink (
		input bus
	);
endinterface

// ==== hdl/ooo_pkg.sv ====
`include "ooo_defines.svh"

package ooo_pkg;

	// Operand from register read, or a CDB broadcast
	typedef struct packed {
		logic valid;
		logic [`OOO_TAG_WIDTH-1:0] tag;
		logic [`OOO_DATA_WIDTH-1:0] data;
	} cdb_t;

	typedef enum logic {
		ADD,
		SUB
	} add_or_sub_t;

	typedef struct packed {
		logic valid;
		logic [`OOO_TAG_WIDTH-1:0] tag;
		add_or_sub_t add_or_sub;
		logic sl2;
		cdb_t [1:0] opd; // [0] is A, [1] is B
	} rs_entry_t;

endpackage

// ==== hdl/ooo_defines.svh ====
`ifndef OOO_DEFINES_SVH
`define OOO_DEFINES_SVH

// Rename tag width, eight tags in flight
`define OOO_TAG_WIDTH 3
// Architectural registers, r0 hardwired to zero
`define OOO_N_GPR 8
`define OOO_DATA_WIDTH 32
`define OOO_IMM_WIDTH 16

`endif
